//--- include/jtframe_consts.svh
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Board services constants
// Reset stretch length, sound sample width and joystick word width
// shared by the board block and its function blocks
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef JTFRAME_CONSTS_SVH
`define JTFRAME_CONSTS_SVH

// Cycles that game_rst is held after the last reset cause is gone
`define JTFRAME_RST_CYCLES 16

// Game sound sample, one word per clk_sys cycle
`define JTFRAME_SND_W 16

// Joystick word as sent by the I/O controller
// right, left, down, up, three buttons, start, coin, pause
`define JTFRAME_JOY_W 10

// Game joystick carries seven live bits, the rest are padding
`define JTFRAME_JOY_USED 7

`endif

//--- sim.f
+incdir+include
src/jtframe_pkg.sv
src/jtframe_reset.sv
src/jtframe_snd_dac.sv
src/jtframe_joy_map.sv
src/jtframe_board.sv
verif/jtframe_board_tb.sv

//--- src/jtframe_board.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Board services
// Game reset, sound DAC and joystick mapping for a MiST-style board
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module jtframe_board #(
    parameter bit SIGNED_SND              = 1'b0,
    parameter bit THREE_BUTTONS           = 1'b0,
    parameter bit GAME_INPUTS_ACTIVE_HIGH = 1'b0
) (
    input  logic                   clk_sys,
    input  logic                   rst_n,
    // Reset causes
    input  logic                   rst_req,
    input  logic                   dip_flip,
    input  logic                   downloading,
    input  logic                   loop_rst,
    output logic                   game_rst,
    // Sound
    input  jtframe_pkg::snd_word_u  snd,
    output logic                   snd_pwm,
    // Joysticks from the I/O controller
    input  jtframe_pkg::board_joy_t board_joystick1,
    input  jtframe_pkg::board_joy_t board_joystick2,
    // Game controls
    output jtframe_pkg::game_joy_t  game_joystick1,
    output jtframe_pkg::game_joy_t  game_joystick2,
    output logic [1:0]             game_coin,
    output logic [1:0]             game_start,
    output logic                   game_pause,
    output logic                   game_service
);

    jtframe_reset u_reset (
        .clk_sys     ( clk_sys     ),
        .rst_n       ( rst_n       ),
        .rst_req     ( rst_req     ),
        .dip_flip    ( dip_flip    ),
        .downloading ( downloading ),
        .loop_rst    ( loop_rst    ),
        .game_rst    ( game_rst    )
    );

    // Runs on the board reset so sound is live during game reset
    jtframe_snd_dac #(
        .SIGNED_SND ( SIGNED_SND )
    ) u_dac (
        .clk_sys ( clk_sys ),
        .rst_n   ( rst_n   ),
        .snd     ( snd     ),
        .snd_pwm ( snd_pwm )
    );

    jtframe_joy_map #(
        .THREE_BUTTONS           ( THREE_BUTTONS           ),
        .GAME_INPUTS_ACTIVE_HIGH ( GAME_INPUTS_ACTIVE_HIGH )
    ) u_joy (
        .clk_sys         ( clk_sys         ),
        .rst_n           ( rst_n           ),
        .board_joystick1 ( board_joystick1 ),
        .board_joystick2 ( board_joystick2 ),
        .game_joystick1  ( game_joystick1  ),
        .game_joystick2  ( game_joystick2  ),
        .game_coin       ( game_coin       ),
        .game_start      ( game_start      ),
        .game_pause      ( game_pause      ),
        .game_service    ( game_service    )
    );

endmodule

`default_nettype wire

//--- src/jtframe_joy_map.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Joystick mapping
// Board joystick words to game joysticks, coin, start, pause and
// service, in the active level the game core expects
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module jtframe_joy_map #(
    parameter bit THREE_BUTTONS           = 1'b0,
    parameter bit GAME_INPUTS_ACTIVE_HIGH = 1'b0
) (
    input  logic                   clk_sys,
    input  logic                   rst_n,
    input  jtframe_pkg::board_joy_t board_joystick1,
    input  jtframe_pkg::board_joy_t board_joystick2,
    output jtframe_pkg::game_joy_t  game_joystick1,
    output jtframe_pkg::game_joy_t  game_joystick2,
    output logic [1:0]             game_coin,
    output logic [1:0]             game_start,
    output logic                   game_pause,     // Always active high
    output logic                   game_service
);

    // XOR mask that turns an active-high bit into the game's level
    localparam logic INV = GAME_INPUTS_ACTIVE_HIGH ? 1'b0 : 1'b1;

    logic [1:0] pause_now;
    logic [1:0] pause_last;     // Edge detector per player
    logic       pause_rise;
    logic       service_now;

    // Reorder one player's controls into the game layout
    function automatic jtframe_pkg::game_joy_t map_joy(
        input jtframe_pkg::board_joy_t b
    );
        jtframe_pkg::game_joy_t g;
        g.unused = '0;
        g.up     = b.up    ^ INV;
        g.down   = b.down  ^ INV;
        g.left   = b.left  ^ INV;
        g.right  = b.right ^ INV;
        g.btn1   = b.btn1  ^ INV;
        g.btn2   = b.btn2  ^ INV;
        g.btn3   = (THREE_BUTTONS ? b.btn3 : 1'b0) ^ INV; // Two-button games
        return g;
    endfunction

    assign pause_now   = {board_joystick2.pause, board_joystick1.pause};
    assign pause_rise  = |(pause_now & ~pause_last);
    assign service_now = board_joystick1.start & board_joystick1.coin;

    // Directions and buttons
    // An all-zero board word maps to the idle pattern
    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            game_joystick1 <= map_joy('0);
            game_joystick2 <= map_joy('0);
        end else begin
            game_joystick1 <= map_joy(board_joystick1);
            game_joystick2 <= map_joy(board_joystick2);
        end
    end

    // Coin, start and service
    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            game_coin    <= {2{INV}};
            game_start   <= {2{INV}};
            game_service <= INV;
        end else begin
            game_coin    <= {board_joystick2.coin,  board_joystick1.coin}  ^ {2{INV}};
            game_start   <= {board_joystick2.start, board_joystick1.start} ^ {2{INV}};
            game_service <= service_now ^ INV;     // Start and coin together on P1
        end
    end

    // Pause toggles once per press from either player
    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            pause_last <= '0;
            game_pause <= 1'b0;
        end else begin
            pause_last <= pause_now;
            if (pause_rise) begin
                game_pause <= ~game_pause;
            end
        end
    end

    // Holding pause must not toggle the state again
    // A change needs a low-to-high step of a board pause bit
    a_pause_on_edge: assert property (
        @(posedge clk_sys) disable iff (!rst_n)
        game_pause != $past(game_pause) |->
            !$past(rst_n) || !$past(rst_n, 2) ||
            ($past(pause_now) & ~$past(pause_now, 2)) != 2'b00
    ) else $error("game_pause changed without a pause press");

endmodule

`default_nettype wire

//--- src/jtframe_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Board services types
// Joystick word layouts and the two readings of a sound sample
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "jtframe_consts.svh"

package jtframe_pkg;

    // I/O controller joystick word, active high
    // Declared MSB first so that right lands on bit 0
    typedef struct packed {
        logic pause;    // bit 9
        logic coin;
        logic start;
        logic btn3;
        logic btn2;
        logic btn1;
        logic up;
        logic down;
        logic left;
        logic right;    // bit 0
    } board_joy_t;

    // Joystick as the game core sees it, in the game's active level
    typedef struct packed {
        logic [`JTFRAME_JOY_W-`JTFRAME_JOY_USED-1:0] unused; // Always zero
        logic up;
        logic down;
        logic left;
        logic right;
        logic btn1;
        logic btn2;
        logic btn3;
    } game_joy_t;

    // One sound word, two encodings
    // s for two's complement cores, u for offset binary cores
    typedef union packed {
        logic signed [`JTFRAME_SND_W-1:0] s;
        logic        [`JTFRAME_SND_W-1:0] u;
    } snd_word_u;

endpackage

`default_nettype wire

//--- src/jtframe_reset.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Game reset generator
// Merges board reset, reset request, flip DIP change, ROM download
// and loader loop reset, then stretches the result into game_rst
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "jtframe_consts.svh"

module jtframe_reset (
    input  logic clk_sys,
    input  logic rst_n,
    input  logic rst_req,
    input  logic dip_flip,      // Any change forces a reset
    input  logic downloading,
    input  logic loop_rst,
    output logic game_rst
);

    localparam int CNT_W = $clog2(`JTFRAME_RST_CYCLES + 1);
    localparam logic [CNT_W-1:0] CNT_LOAD = CNT_W'(`JTFRAME_RST_CYCLES);

    logic             flip_r;       // Last seen DIP value
    logic             flip_chg;
    logic             req_r;
    logic             dl_r;
    logic             loop_r;
    logic             chg_r;
    logic             rst_r;        // Board reset seen last cycle
    logic             cause_now;
    logic             cause_r;
    logic [CNT_W-1:0] cnt;

    assign flip_chg  = dip_flip != flip_r;
    assign cause_now = rst_req | downloading | loop_rst | flip_chg;
    assign cause_r   = req_r | dl_r | loop_r | chg_r;

    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            flip_r <= dip_flip;     // No false flip change on release
            req_r  <= 1'b0;
            dl_r   <= 1'b0;
            loop_r <= 1'b0;
            chg_r  <= 1'b0;
            rst_r  <= 1'b1;
        end else begin
            flip_r <= dip_flip;
            req_r  <= rst_req;
            dl_r   <= downloading;
            loop_r <= loop_rst;
            chg_r  <= flip_chg;
            rst_r  <= 1'b0;
        end
    end

    // Stretch counter
    // The board reset adds one cycle through rst_r
    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            cnt <= CNT_LOAD;
        end else if (cause_now || rst_r) begin
            cnt <= CNT_LOAD;
        end else if (cnt != '0) begin
            cnt <= cnt - 1'b1;
        end
    end

    assign game_rst = (cnt != '0) | cause_r;

    // Download must keep the game in reset for the stretch after it ends
    a_dl_holds_rst: assert property (
        @(posedge clk_sys) disable iff (!rst_n)
        dl_r |=> game_rst [*`JTFRAME_RST_CYCLES-1]
    ) else $error("game_rst dropped too early after downloading");

endmodule

`default_nettype wire

//--- src/jtframe_snd_dac.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sound DAC
// First-order sigma-delta modulator, 16-bit sample in, one-bit
// pulse-density stream out for the board's audio pins
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "jtframe_consts.svh"

module jtframe_snd_dac #(
    parameter bit SIGNED_SND = 1'b0    // 1 for two's complement samples
) (
    input  logic                  clk_sys,
    input  logic                  rst_n,
    input  jtframe_pkg::snd_word_u snd,
    output logic                  snd_pwm
);

    localparam int W = `JTFRAME_SND_W;
    localparam logic [W-1:0] SND_MIN = {SIGNED_SND, {(W-1){1'b0}}}; // Lowest sample code

    logic [W-1:0] snd_u;    // Offset binary sample
    logic [W-1:0] acc;
    logic [W:0]   sum;      // Top bit is the carry

    // Signed samples move to offset binary by flipping the sign bit
    always_comb begin
        if (SIGNED_SND) begin
            snd_u = {~snd.s[W-1], snd.s[W-2:0]};
        end else begin
            snd_u = snd.u;
        end
    end

    assign sum = {1'b0, acc} + {1'b0, snd_u};

    // Carry rate follows the sample level
    // Full scale gives a carry on nearly every cycle
    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            acc     <= '0;
            snd_pwm <= 1'b0;
        end else begin
            acc     <= sum[W-1:0];
            snd_pwm <= sum[W];
        end
    end

    // The lowest sample level keeps the output silent
    a_silent_low: assert property (
        @(posedge clk_sys) disable iff (!rst_n)
        $past(snd.u) == SND_MIN |-> !snd_pwm
    ) else $error("snd_pwm high after the lowest sample");

endmodule

`default_nettype wire

//--- verif/jtframe_board_tb.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Board services testbench
// Table-driven checks of game reset, joystick mapping, pause toggle
// and the sigma-delta sound output
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "jtframe_consts.svh"

module jtframe_board_tb;

    localparam int RST_CYCLES = `JTFRAME_RST_CYCLES;
    localparam int SND_N      = 256;    // Cycles per sound measurement

    typedef enum logic [2:0] {
        T_BOOT, T_JOY_RAND, T_JOY_WORD, T_PAUSE, T_CAUSE, T_SND
    } test_kind_e;

    typedef struct packed {
        test_kind_e  kind;
        logic [1:0]  sel;       // Reset cause or player
        logic [15:0] len;       // Cycles the entry takes
        logic [15:0] stim1;
        logic [15:0] stim2;
        logic [15:0] exp;
    } entry_t;

    logic                    clk_sys;
    logic                    rst_n;
    logic                    rst_req;
    logic                    dip_flip;
    logic                    downloading;
    logic                    loop_rst;
    logic                    game_rst;
    jtframe_pkg::snd_word_u  snd;
    logic                    snd_pwm;
    jtframe_pkg::board_joy_t board_joystick1;
    jtframe_pkg::board_joy_t board_joystick2;
    jtframe_pkg::game_joy_t  game_joystick1;
    jtframe_pkg::game_joy_t  game_joystick2;
    logic [1:0]              game_coin;
    logic [1:0]              game_start;
    logic                    game_pause;
    logic                    game_service;

    entry_t table_q[$];
    int     cycle_cnt;
    int     cycle_limit;
    logic   pause_exp;      // Expected pause state

    jtframe_board #(
        .SIGNED_SND              ( 1'b1 ),
        .THREE_BUTTONS           ( 1'b0 ),
        .GAME_INPUTS_ACTIVE_HIGH ( 1'b0 )
    ) jtframe_board_i (
        .clk_sys         ( clk_sys         ),
        .rst_n           ( rst_n           ),
        .rst_req         ( rst_req         ),
        .dip_flip        ( dip_flip        ),
        .downloading     ( downloading     ),
        .loop_rst        ( loop_rst        ),
        .game_rst        ( game_rst        ),
        .snd             ( snd             ),
        .snd_pwm         ( snd_pwm         ),
        .board_joystick1 ( board_joystick1 ),
        .board_joystick2 ( board_joystick2 ),
        .game_joystick1  ( game_joystick1  ),
        .game_joystick2  ( game_joystick2  ),
        .game_coin       ( game_coin       ),
        .game_start      ( game_start      ),
        .game_pause      ( game_pause      ),
        .game_service    ( game_service    )
    );

    always #20 clk_sys = ~clk_sys;

    always @(posedge clk_sys) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("timeout: the tests did not finish within %0d cycles", cycle_limit);
            $display("TESTS FAILED");
            $fatal(1);
        end
    end

    // Inputs change 2 units after the edge, outputs are read there too
    task automatic next_cycle();
        @(posedge clk_sys);
        #2;
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("mismatch at %0t: %s actual %0h expected %0h",
                     $time, name, actual, expected);
            $display("TESTS FAILED");
            $fatal(1);
        end
    endtask

    // Active-low game level, btn3 idle on a two-button game
    function automatic jtframe_pkg::game_joy_t expected_game_joy(
        input jtframe_pkg::board_joy_t b
    );
        jtframe_pkg::game_joy_t g;
        g       = '0;
        g.up    = ~b.up;
        g.down  = ~b.down;
        g.left  = ~b.left;
        g.right = ~b.right;
        g.btn1  = ~b.btn1;
        g.btn2  = ~b.btn2;
        g.btn3  = 1'b1;
        return g;
    endfunction

    task automatic compare_controls(input jtframe_pkg::board_joy_t b1,
                                    input jtframe_pkg::board_joy_t b2);
        logic [1:0] coin_exp;
        logic [1:0] start_exp;
        logic       service_exp;
        coin_exp    = ~{b2.coin, b1.coin};
        start_exp   = ~{b2.start, b1.start};
        service_exp = ~(b1.start & b1.coin);
        check_value("game_joystick1", game_joystick1, expected_game_joy(b1));
        check_value("game_joystick2", game_joystick2, expected_game_joy(b2));
        check_value("game_coin", game_coin, coin_exp);
        check_value("game_start", game_start, start_exp);
        check_value("game_service", game_service, service_exp);
        check_value("game_pause", game_pause, pause_exp);
    endtask

    task automatic drive_cause(input logic [1:0] sel, input logic level);
        case (sel)
            2'd0: rst_req = level;
            2'd1: if (level) dip_flip = ~dip_flip;     // Only the change counts
            2'd2: downloading = level;
            default: loop_rst = level;
        endcase
    endtask

    task automatic apply_reset();
        rst_n = 1'b0;
        repeat (4) next_cycle();
        rst_n = 1'b1;
        pause_exp = 1'b0;
    endtask

    task automatic boot_and_release();
        int i;
        apply_reset();
        check_value("game_rst", game_rst, 1);
        compare_controls('0, '0);
        for (i = 0; i < RST_CYCLES; i++) begin
            next_cycle();
            check_value("game_rst", game_rst, 1);
            compare_controls('0, '0);
        end
        next_cycle();
        check_value("game_rst", game_rst, 0);
    endtask

    task automatic random_joystick_words(input int count);
        jtframe_pkg::board_joy_t b1;
        jtframe_pkg::board_joy_t b2;
        int i;
        for (i = 0; i < count; i++) begin
            b1 = $urandom() & 10'h1ff;  // Pause bit kept low here
            b2 = $urandom() & 10'h1ff;
            board_joystick1 = b1;
            board_joystick2 = b2;
            next_cycle();
            compare_controls(b1, b2);
        end
        board_joystick1 = '0;
        board_joystick2 = '0;
        next_cycle();
        compare_controls('0, '0);
    endtask

    task automatic fixed_joystick_word(input entry_t e);
        board_joystick1 = e.stim1[9:0];
        board_joystick2 = e.stim2[9:0];
        next_cycle();
        compare_controls(e.stim1[9:0], e.stim2[9:0]);
        check_value("game_service", game_service, e.exp);
        board_joystick1 = '0;
        board_joystick2 = '0;
        next_cycle();
        compare_controls('0, '0);
    endtask

    task automatic press_pause(input entry_t e);
        int i;
        pause_exp = ~pause_exp;
        if (e.sel == 2'd0) begin
            board_joystick1.pause = 1'b1;
        end else begin
            board_joystick2.pause = 1'b1;
        end
        for (i = 0; i < e.stim1; i++) begin     // Held high, one toggle only
            next_cycle();
            check_value("game_pause", game_pause, pause_exp);
        end
        board_joystick1 = '0;
        board_joystick2 = '0;
        for (i = 0; i < 2; i++) begin
            next_cycle();
            check_value("game_pause", game_pause, pause_exp);
        end
    endtask

    task automatic hold_reset_cause(input entry_t e);
        int i;
        check_value("game_rst", game_rst, 0);
        drive_cause(e.sel, 1'b1);
        for (i = 0; i < e.stim1; i++) begin
            next_cycle();
            check_value("game_rst", game_rst, 1);
        end
        drive_cause(e.sel, 1'b0);
        for (i = 1; i < e.exp; i++) begin
            next_cycle();
            check_value("game_rst", game_rst, 1);
        end
        next_cycle();
        check_value("game_rst", game_rst, 0);
    endtask

    task automatic measure_sound(input entry_t e);
        int high_cnt;
        int i;
        snd.s = e.stim1;
        apply_reset();
        high_cnt = 0;
        for (i = 0; i < SND_N; i++) begin
            next_cycle();
            if (snd_pwm) high_cnt++;
        end
        check_value("snd_pwm high count", high_cnt, e.exp);
    endtask

    function automatic int entry_len(input test_kind_e kind, input logic [15:0] stim1);
        case (kind)
            T_BOOT:     return 4 + RST_CYCLES + 1;
            T_JOY_RAND: return stim1 + 1;
            T_JOY_WORD: return 2;
            T_PAUSE:    return stim1 + 2;
            T_CAUSE:    return stim1 + RST_CYCLES;
            default:    return 4 + SND_N;
        endcase
    endfunction

    function automatic void add_entry(input test_kind_e kind, input logic [1:0] sel,
                                      input logic [15:0] stim1, input logic [15:0] stim2,
                                      input logic [15:0] exp);
        entry_t e;
        e.kind  = kind;
        e.sel   = sel;
        e.len   = entry_len(kind, stim1);
        e.stim1 = stim1;
        e.stim2 = stim2;
        e.exp   = exp;
        table_q.push_back(e);
    endfunction

    // Sound expectations are floor(256 * u / 65536) with u = sample ^ 16'h8000
    function automatic void fill_table();
        add_entry(T_BOOT,     2'd0, 16'd0,    16'd0,    16'd0);
        add_entry(T_JOY_RAND, 2'd0, 16'd24,   16'd0,    16'd0);
        add_entry(T_JOY_WORD, 2'd0, 16'h180,  16'h000,  16'd0);   // P1 start and coin
        add_entry(T_JOY_WORD, 2'd0, 16'h100,  16'h080,  16'd1);
        add_entry(T_PAUSE,    2'd0, 16'd1,    16'd0,    16'd0);
        add_entry(T_PAUSE,    2'd1, 16'd5,    16'd0,    16'd0);
        add_entry(T_PAUSE,    2'd0, 16'd3,    16'd0,    16'd0);
        add_entry(T_CAUSE,    2'd0, 16'd3,    16'd0,    RST_CYCLES);
        add_entry(T_CAUSE,    2'd1, 16'd1,    16'd0,    RST_CYCLES);
        add_entry(T_CAUSE,    2'd2, 16'd20,   16'd0,    RST_CYCLES);
        add_entry(T_CAUSE,    2'd3, 16'd2,    16'd0,    RST_CYCLES);
        add_entry(T_CAUSE,    2'd1, 16'd1,    16'd0,    RST_CYCLES);
        add_entry(T_SND,      2'd0, 16'h0000, 16'd0,    16'd128);
        add_entry(T_SND,      2'd0, 16'h8000, 16'd0,    16'd0);
        add_entry(T_SND,      2'd0, 16'h7fff, 16'd0,    16'd255);
        add_entry(T_SND,      2'd0, 16'hc000, 16'd0,    16'd64);
        add_entry(T_SND,      2'd0, 16'h1234, 16'd0,    16'd146);
    endfunction

    initial begin
        int total;
        int i;
        clk_sys         = 1'b0;
        rst_n           = 1'b0;
        rst_req         = 1'b0;
        dip_flip        = 1'b0;
        downloading     = 1'b0;
        loop_rst        = 1'b0;
        snd             = '0;
        board_joystick1 = '0;
        board_joystick2 = '0;
        pause_exp       = 1'b0;
        cycle_cnt       = 0;
        void'($urandom(32'hd3f7_f5d7));
        fill_table();
        total = 0;
        for (i = 0; i < table_q.size(); i++) total += table_q[i].len;
        cycle_limit = 2 * total + 100;
        for (i = 0; i < table_q.size(); i++) begin
            case (table_q[i].kind)
                T_BOOT:     boot_and_release();
                T_JOY_RAND: random_joystick_words(table_q[i].stim1);
                T_JOY_WORD: fixed_joystick_word(table_q[i]);
                T_PAUSE:    press_pause(table_q[i]);
                T_CAUSE:    hold_reset_cause(table_q[i]);
                default:    measure_sound(table_q[i]);
            endcase
        end
        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire
